// File: Makefile
TOP := tb_aud_rec

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build the testbench with Verilator and run it"
	@echo "  make clean  remove the Verilator build output"
	@echo "  make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) -f files.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// File: design/aud_rec_pkg.sv
package aud_rec_pkg;

    localparam int SAMPLE_W      = 16;
    localparam int ADDR_W        = 20;
    localparam int REC_WORDS_MAX = 1024000;   // 1000 x 1024 words, just under a full 1M SRAM.

    // one finished left-channel word, valid for a single cycle.
    typedef struct packed {
        logic                valid;
        logic [SAMPLE_W-1:0] sample;
    } audio_word_t;

    // one SRAM write request from the sequencer.
    typedef struct packed {
        logic                req;
        logic [ADDR_W-1:0]   addr;
        logic [SAMPLE_W-1:0] data;
    } sram_req_t;

    typedef enum logic [1:0] {
        REC_IDLE,
        REC_RUN,
        REC_PAUSE,
        REC_DONE
    } rec_state_e;

    // setup, strobe and hold each take one cycle.
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SETUP,
        WR_STROBE,
        WR_HOLD
    } wr_phase_e;

endpackage

// File: design/aud_rec_top.sv
`timescale 1ns/1ns

module aud_rec_top import aud_rec_pkg::*; #(
    parameter int unsigned MAX_WORDS = REC_WORDS_MAX
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_lrc,
    input  logic                i_data,
    input  logic                i_start,
    input  logic                i_pause,
    input  logic                i_stop,
    output logic [ADDR_W-1:0]   o_sram_addr,
    output logic [SAMPLE_W-1:0] o_sram_data,
    output logic                o_sram_we_n,
    output logic                o_recording,
    output logic                o_paused,
    output logic                o_done,
    output logic [ADDR_W-1:0]   o_length
);

audio_word_t cap_word;                                  // left words out of the serial input.
sram_req_t   seq_req;

i2s_left_capture u_capture (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_lrc   (i_lrc),
    .i_data  (i_data),
    .o_word  (cap_word)
);

rec_sequencer #(
    .MAX_WORDS (MAX_WORDS)
) u_sequencer (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_start     (i_start),
    .i_pause     (i_pause),
    .i_stop      (i_stop),
    .i_word      (cap_word),
    .o_req       (seq_req),
    .o_recording (o_recording),
    .o_paused    (o_paused),
    .o_done      (o_done),
    .o_length    (o_length)
);

sram_write_port u_write (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_req       (seq_req),
    .o_sram_addr (o_sram_addr),
    .o_sram_data (o_sram_data),
    .o_sram_we_n (o_sram_we_n)
);

endmodule

// File: design/i2s_left_capture.sv
`timescale 1ns/1ns

module i2s_left_capture import aud_rec_pkg::*; (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_lrc,
    input  logic        i_data,
    output audio_word_t o_word
);

logic                lrc_r;
logic [4:0]          cnt_r, cnt_w;
logic [SAMPLE_W-1:0] shift_r, shift_w;
logic                valid_r, valid_w;
logic                left_start;
logic                left_shift;

// The left phase opens on the first low sample after a high one.
assign left_start = lrc_r && !i_lrc;

// keep shifting until the word is full, later bits are ignored.
assign left_shift = !i_lrc && (cnt_r != 5'd0) && (cnt_r < 5'(SAMPLE_W));

always_comb begin
    cnt_w   = cnt_r;
    shift_w = shift_r;
    valid_w = 1'b0;
    if (i_lrc) begin
        cnt_w = 5'd0;                                   // a short word is dropped here.
    end
    else if (left_start || left_shift) begin
        shift_w = {shift_r[SAMPLE_W-2:0], i_data};      // msb arrives first.
        cnt_w   = left_start ? 5'd1 : cnt_r + 5'd1;
        valid_w = (cnt_r == 5'(SAMPLE_W - 1));          // this edge stores the last bit.
    end
end

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        lrc_r   <= 1'b0;                                // no word starts mid-phase after reset.
        cnt_r   <= 5'd0;
        valid_r <= 1'b0;
    end
    else begin
        lrc_r   <= i_lrc;
        cnt_r   <= cnt_w;
        valid_r <= valid_w;
    end
end

always_ff @(posedge i_clk) begin
    shift_r <= shift_w;
end

assign o_word.valid  = valid_r;
assign o_word.sample = shift_r;

// The strobe must be a single pulse per left phase.
a_valid_single : assert property (
    @(posedge i_clk) disable iff (i_rst_n)
    o_word.valid |=> !o_word.valid
) else $error("capture strobe lasted more than one cycle");

endmodule

// File: design/rec_sequencer.sv
`timescale 1ns/1ns

module rec_sequencer import aud_rec_pkg::*; #(
    parameter int unsigned MAX_WORDS = REC_WORDS_MAX
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_start,
    input  logic              i_pause,
    input  logic              i_stop,
    input  audio_word_t       i_word,
    output sram_req_t         o_req,
    output logic              o_recording,
    output logic              o_paused,
    output logic              o_done,
    output logic [ADDR_W-1:0] o_length
);

rec_state_e        state_r, state_w;
logic [ADDR_W-1:0] wr_addr_r, wr_addr_w;
logic              word_take;
logic              limit_hit;

// only words that land while running are recorded.
assign word_take = (state_r == REC_RUN) && i_word.valid;

// the write that fills the last allowed slot ends the take.
assign limit_hit = word_take && (wr_addr_r == ADDR_W'(MAX_WORDS - 1));

always_comb begin
    state_w   = state_r;
    wr_addr_w = wr_addr_r;
    case (state_r)
        REC_IDLE: begin
            if (i_start) begin
                wr_addr_w = '0;                         // a new take starts at word 0.
                state_w   = REC_RUN;
            end
        end
        REC_RUN: begin
            if (word_take) begin
                wr_addr_w = wr_addr_r + 1'b1;
            end
            if (i_stop || limit_hit) begin
                state_w = REC_DONE;
            end
            else if (i_pause) begin
                state_w = REC_PAUSE;
            end
        end
        REC_PAUSE: begin
            if (i_stop) begin
                state_w = REC_DONE;
            end
            else if (i_pause) begin
                state_w = REC_RUN;                      // resume at the next address.
            end
        end
        REC_DONE: begin
            state_w = REC_IDLE;
        end
        default: begin
            state_w = REC_IDLE;
        end
    endcase
end

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        state_r   <= REC_IDLE;
        wr_addr_r <= '0;
    end
    else begin
        state_r   <= state_w;
        wr_addr_r <= wr_addr_w;
    end
end

// request goes out in the same cycle as the word strobe.
assign o_req.req  = word_take;
assign o_req.addr = wr_addr_r;
assign o_req.data = i_word.sample;

assign o_recording = (state_r == REC_RUN) || (state_r == REC_PAUSE);
assign o_paused    = (state_r == REC_PAUSE);
assign o_done      = (state_r == REC_DONE);

// Every write moves the address by one, so it doubles as the word count.
assign o_length = wr_addr_r;

// a request only comes while running and never past the last allowed slot.
a_req_in_run : assert property (
    @(posedge i_clk) disable iff (i_rst_n)
    o_req.req |-> (state_r == REC_RUN) && (o_req.addr < ADDR_W'(MAX_WORDS))
) else $error("write request outside recording or beyond the word limit");

a_done_pulse : assert property (
    @(posedge i_clk) disable iff (i_rst_n)
    o_done |=> !o_done
) else $error("done held for more than one cycle");

endmodule

// File: design/sram_write_port.sv
`timescale 1ns/1ns

module sram_write_port import aud_rec_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  sram_req_t           i_req,
    output logic [ADDR_W-1:0]   o_sram_addr,
    output logic [SAMPLE_W-1:0] o_sram_data,
    output logic                o_sram_we_n
);

wr_phase_e           phase_r, phase_w;
logic                we_n_r, we_n_w;
logic [ADDR_W-1:0]   addr_r;
logic [SAMPLE_W-1:0] data_r;
logic                load;

assign load = (phase_r == WR_IDLE) && i_req.req;

always_comb begin
    phase_w = phase_r;
    we_n_w  = 1'b1;
    case (phase_r)
        WR_IDLE: begin
            if (i_req.req) begin
                phase_w = WR_SETUP;                     // address and data settle first.
            end
        end
        WR_SETUP: begin
            phase_w = WR_STROBE;
            we_n_w  = 1'b0;                             // low for the strobe cycle only.
        end
        WR_STROBE: begin
            phase_w = WR_HOLD;
        end
        WR_HOLD: begin
            phase_w = WR_IDLE;                          // hold ends, bus is free again.
        end
        default: begin
            phase_w = WR_IDLE;
        end
    endcase
end

always_ff @(posedge i_clk) begin
    if (i_rst_n) begin
        phase_r <= WR_IDLE;
        we_n_r  <= 1'b1;
    end
    else begin
        phase_r <= phase_w;
        we_n_r  <= we_n_w;
    end
end

always_ff @(posedge i_clk) begin
    if (load) begin
        addr_r <= i_req.addr;
        data_r <= i_req.data;
    end
end

assign o_sram_addr = addr_r;
assign o_sram_data = data_r;
assign o_sram_we_n = we_n_r;

// words come 17 or more cycles apart, so a write is never still in flight.
a_req_when_idle : assert property (
    @(posedge i_clk) disable iff (i_rst_n)
    i_req.req |-> (phase_r == WR_IDLE)
) else $error("write request arrived while a write was in progress");

endmodule

// File: files.f
design/aud_rec_pkg.sv
design/i2s_left_capture.sv
design/rec_sequencer.sv
design/sram_write_port.sv
design/aud_rec_top.sv
tests/tb_i2s_source.sv
tests/tb_aud_rec.sv

// File: tests/tb_aud_rec.sv
`timescale 1ns/1ns

module tb_aud_rec import aud_rec_pkg::*; ();

localparam int WORDS_LIMIT    = 6;
localparam int FRAME_CYCLES   = 40;
localparam int TIMEOUT_CYCLES = 40 * FRAME_CYCLES + 200;

logic                clk, rst_n, lrc, data_bit, start, pause, stop;
logic [ADDR_W-1:0]   sram_addr, length;
logic [SAMPLE_W-1:0] sram_data, src_word;
logic                sram_we_n, recording, paused, done, src_mark;

// expected behavior, built from the word marks and the control pulses.
logic [SAMPLE_W-1:0] exp_data_mem [0:63];
logic [ADDR_W-1:0]   exp_addr_mem [0:63];
logic                exp_active, exp_run, exp_paused, started;
int                  exp_cnt, take_cnt;

logic                we_prev, we_fall, exp_valid;
logic [ADDR_W-1:0]   exp_addr_now;
logic [SAMPLE_W-1:0] exp_data_now;
int                  wr_seen, take_writes, done_seen;
int                  mismatches, failures;
int                  cycles = 0;

aud_rec_top #(
    .MAX_WORDS (WORDS_LIMIT)
) dut (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_lrc       (lrc),
    .i_data      (data_bit),
    .i_start     (start),
    .i_pause     (pause),
    .i_stop      (stop),
    .o_sram_addr (sram_addr),
    .o_sram_data (sram_data),
    .o_sram_we_n (sram_we_n),
    .o_recording (recording),
    .o_paused    (paused),
    .o_done      (done),
    .o_length    (length)
);

tb_i2s_source u_source (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .o_lrc       (lrc),
    .o_data      (data_bit),
    .o_left_word (src_word),
    .o_left_mark (src_mark)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

always @(posedge clk) begin
    if (rst_n) begin
        exp_cnt    <= 0;
        take_cnt   <= 0;
        exp_active <= 1'b0;
        exp_run    <= 1'b0;
        exp_paused <= 1'b0;
        started    <= 1'b0;
    end
    else if (src_mark && exp_run) begin
        exp_data_mem[exp_cnt[5:0]] <= src_word;
        exp_addr_mem[exp_cnt[5:0]] <= ADDR_W'(take_cnt);
        exp_cnt  <= exp_cnt + 1;
        take_cnt <= take_cnt + 1;
        if (take_cnt + 1 == WORDS_LIMIT) begin
            exp_run    <= 1'b0;                         // the limit ends the take.
            exp_active <= 1'b0;
        end
    end
    else if (start && !exp_active) begin
        exp_active <= 1'b1;
        exp_run    <= 1'b1;
        take_cnt   <= 0;
        started    <= 1'b1;
    end
    else if (stop && exp_active) begin
        exp_active <= 1'b0;
        exp_run    <= 1'b0;
        exp_paused <= 1'b0;
    end
    else if (pause && exp_active) begin
        exp_run    <= !exp_run;
        exp_paused <= exp_run;
    end
end

// scoreboard, counts each falling write enable.
always @(posedge clk) begin
    if (rst_n) begin
        we_prev     <= 1'b1;
        wr_seen     <= 0;
        take_writes <= 0;
        done_seen   <= 0;
    end
    else begin
        we_prev <= sram_we_n;
        if (start) begin
            take_writes <= 0;
        end
        else if (we_fall) begin
            take_writes <= take_writes + 1;
        end
        if (we_fall) begin
            wr_seen <= wr_seen + 1;
        end
        if (done) begin
            done_seen <= done_seen + 1;
        end
    end
end

assign we_fall      = we_prev && !sram_we_n;
assign exp_valid    = (wr_seen < exp_cnt);
assign exp_addr_now = exp_addr_mem[wr_seen[5:0]];
assign exp_data_now = exp_data_mem[wr_seen[5:0]];

a_quiet_before_start : assert property (@(posedge clk) disable iff (rst_n)
    !started |-> (sram_we_n && !recording && !paused && !done)
) else begin
    mismatches++;
    $display("mismatch at %0t: SRAM or status output active before any start", $time);
end

a_write_expected : assert property (@(posedge clk) disable iff (rst_n)
    we_fall |-> exp_valid
) else begin
    failures++;
    $display("an SRAM write happened at %0t with no recorded word pending", $time);
end

a_write_addr : assert property (@(posedge clk) disable iff (rst_n)
    (we_fall && exp_valid) |-> (sram_addr == exp_addr_now)
) else begin
    mismatches++;
    $display("mismatch at %0t: write address %0d, expected %0d", $time,
             $sampled(sram_addr), $sampled(exp_addr_now));
end

a_write_data : assert property (@(posedge clk) disable iff (rst_n)
    (we_fall && exp_valid) |-> (sram_data == exp_data_now)
) else begin
    mismatches++;
    $display("mismatch at %0t: write data %h, expected %h", $time,
             $sampled(sram_data), $sampled(exp_data_now));
end

// setup, strobe and hold all see the same address and data.
a_setup_stable : assert property (@(posedge clk) disable iff (rst_n)
    we_fall |-> ($stable(sram_addr) && $stable(sram_data))
) else begin
    mismatches++;
    $display("mismatch at %0t: address or data moved during write setup", $time);
end

a_strobe_hold : assert property (@(posedge clk) disable iff (rst_n)
    !sram_we_n |=> (sram_we_n && $stable(sram_addr) && $stable(sram_data))
) else begin
    mismatches++;
    $display("mismatch at %0t: write strobe too long or hold not stable", $time);
end

a_pause_level : assert property (@(posedge clk) disable iff (rst_n)
    (paused == exp_paused) && (!paused || sram_we_n)
) else begin
    mismatches++;
    $display("mismatch at %0t: o_paused is %0d, expected %0d, or a write while paused",
             $time, $sampled(paused), $sampled(exp_paused));
end

a_done_single : assert property (@(posedge clk) disable iff (rst_n)
    done |=> !done
) else begin
    mismatches++;
    $display("mismatch at %0t: o_done held for more than one cycle", $time);
end

a_done_length : assert property (@(posedge clk) disable iff (rst_n)
    done |-> (length == ADDR_W'(take_cnt))
) else begin
    mismatches++;
    $display("mismatch at %0t: o_length %0d at done, expected %0d", $time,
             $sampled(length), $sampled(take_cnt));
end

task check_level(input string what, input int got, input int want);
    assert (got == want) else begin
        mismatches++;
        $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
    end
endtask

task skip_left_words(input int n);
    repeat (n) begin
        @(posedge clk);
        while (!src_mark) begin
            @(posedge clk);
        end
    end
endtask

task send_control(input logic do_start, input logic do_pause, input logic do_stop);
    repeat (8) @(posedge clk);                          // lands in the right-channel phase.
    start <= do_start;
    pause <= do_pause;
    stop  <= do_stop;
    @(posedge clk);
    start <= 1'b0;
    pause <= 1'b0;
    stop  <= 1'b0;
    @(negedge clk);
endtask

initial begin
    rst_n      = 1'b1;
    start      = 1'b0;
    pause      = 1'b0;
    stop       = 1'b0;
    mismatches = 0;
    failures   = 0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b0;

    skip_left_words(2);                                 // nothing may be written yet.
    send_control(1'b1, 1'b0, 1'b0);
    check_level("o_recording after start", int'(recording), 1);
    skip_left_words(2);
    send_control(1'b0, 1'b1, 1'b0);
    check_level("o_paused after pause", int'(paused), 1);
    skip_left_words(2);
    send_control(1'b0, 1'b1, 1'b0);
    check_level("o_paused after resume", int'(paused), 0);
    skip_left_words(2);
    send_control(1'b0, 1'b0, 1'b1);
    skip_left_words(2);
    @(negedge clk);
    check_level("done pulses after stop", done_seen, 1);
    check_level("o_recording after stop", int'(recording), 0);
    check_level("o_length after stop", int'(length), take_writes);

    // second take runs into the word limit.
    send_control(1'b1, 1'b0, 1'b0);
    skip_left_words(8);
    @(negedge clk);
    check_level("done pulses after limit", done_seen, 2);
    check_level("o_recording after limit", int'(recording), 0);
    check_level("o_length after limit", int'(length), WORDS_LIMIT);
    check_level("writes in limited take", take_writes, WORDS_LIMIT);
    check_level("writes seen in total", wr_seen, exp_cnt);

    $display("writes checked %0d of %0d expected, %0d mismatches, %0d other errors",
             wr_seen, exp_cnt, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
        $display("All tests passed");
    end
    else begin
        $display("Some tests failed");
    end
    $finish;
end

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
        $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("writes checked %0d of %0d expected, %0d mismatches, %0d other errors",
                 wr_seen, exp_cnt, mismatches, failures + 1);
        $display("Some tests failed");
        $finish;
    end
end

endmodule

// File: tests/tb_i2s_source.sv
`timescale 1ns/1ns

module tb_i2s_source import aud_rec_pkg::*; (
    input  logic                i_clk,
    input  logic                i_rst_n,
    output logic                o_lrc,
    output logic                o_data,
    output logic [SAMPLE_W-1:0] o_left_word,
    output logic                o_left_mark
);

localparam int HALF_CYCLES = 20;                        // cycles per channel phase.

integer              seed;
logic [SAMPLE_W-1:0] left_w;
logic [SAMPLE_W-1:0] right_w;

initial begin
    seed        = 11;
    left_w      = '0;
    right_w     = '0;
    o_lrc       = 1'b1;
    o_data      = 1'b0;
    o_left_word = '0;
    o_left_mark = 1'b0;
    @(posedge i_clk);
    while (i_rst_n) begin
        @(posedge i_clk);
    end
    forever begin
        left_w  = SAMPLE_W'($random(seed));
        right_w = SAMPLE_W'($random(seed));
        for (int c = 0; c < HALF_CYCLES; c++) begin
            @(posedge i_clk);
            o_lrc       <= 1'b0;
            o_data      <= (c < SAMPLE_W) ? left_w[SAMPLE_W-1-c] : 1'b0;
            o_left_mark <= (c == SAMPLE_W - 1);         // goes out with the last bit.
            if (c == SAMPLE_W - 1) begin
                o_left_word <= left_w;
            end
        end
        // Right channel goes on the wire too, the recorder must ignore it.
        for (int c = 0; c < HALF_CYCLES; c++) begin
            @(posedge i_clk);
            o_lrc       <= 1'b1;
            o_data      <= (c < SAMPLE_W) ? right_w[SAMPLE_W-1-c] : 1'b0;
            o_left_mark <= 1'b0;
        end
    end
end

endmodule
